// ==== files.f ====
hdl/pipe_pkg.sv
hdl/hazard_unit.sv
hdl/pipe_ctrl.sv
hdl/atom_fsm.sv
hdl/mtimer.sv
hdl/fetch_pc.sv
hdl/pipe_top.sv
tests/tb_pipe_top.sv

// ==== hdl/atom_fsm.sv ====
// atomic read-modify-write sequencer
// IDLE, LOCK, READ, WRITE walk with busy outside IDLE
`timescale 1ns/1ps

module atom_fsm (
    input  logic clk,
    input  logic reset_i,
    // one-cycle request to start an atomic op
    input  logic atom_start_i,
    output logic atom_busy_o
);

    logic [pipe_pkg::ATOM_STATE_WIDTH-1:0] state_q;
    logic [pipe_pkg::ATOM_STATE_WIDTH-1:0] state_d;

    // next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            pipe_pkg::ATOM_IDLE: begin
                // starts only count here
                if (atom_start_i) begin
                    state_d = pipe_pkg::ATOM_LOCK;
                end
            end
            pipe_pkg::ATOM_LOCK: begin
                // reservation taken
                state_d = pipe_pkg::ATOM_READ;
            end
            pipe_pkg::ATOM_READ: begin
                // old value fetched
                state_d = pipe_pkg::ATOM_WRITE;
            end
            pipe_pkg::ATOM_WRITE: begin
                // result written back, release
                state_d = pipe_pkg::ATOM_IDLE;
            end
            default: begin
                state_d = pipe_pkg::ATOM_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= pipe_pkg::ATOM_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // busy straight from state, one cycle per phase
    assign atom_busy_o = (state_q != pipe_pkg::ATOM_IDLE);

    // busy window is bounded by the sequence length
    property p_busy_bounded;
        @(posedge clk) disable iff (reset_i)
            $rose(atom_busy_o) |-> ##[1:pipe_pkg::ATOM_BUSY_CYCLES] !atom_busy_o;
    endproperty

    a_busy_bounded: assert property (p_busy_bounded)
        else $error("atomic busy longer than the sequence");

endmodule

// ==== hdl/fetch_pc.sv ====
// fetch program counter for instruction pairs
// trap, then jump, then stall, else step
`timescale 1ns/1ps

module fetch_pc (
    input  logic                                 clk,
    input  logic                                 reset_i,
    // fetch stall/flush bus
    input  logic [pipe_pkg::CU_BUS_WIDTH-1:0]    fetch_bus_i,
    // granted jump from the controller
    input  logic                                 jump_flag_i,
    input  logic [pipe_pkg::INST_ADDR_WIDTH-1:0] jump_addr_i,
    // interrupt from the timer
    input  logic                                 trap_i,
    output logic [pipe_pkg::INST_ADDR_WIDTH-1:0] pc_o
);

    logic [pipe_pkg::INST_ADDR_WIDTH-1:0] pc_d;
    logic                                 fetch_stall;

    assign fetch_stall = fetch_bus_i[pipe_pkg::CU_STALL];

    // next pc by priority
    always_comb begin
        if (trap_i) begin
            pc_d = pipe_pkg::TRAP_VEC;
        end else if (jump_flag_i) begin
            pc_d = jump_addr_i;
        end else if (fetch_stall) begin
            // hold current pair
            pc_d = pc_o;
        end else begin
            pc_d = pc_o + pipe_pkg::FETCH_STEP;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_o <= pipe_pkg::RESET_PC;
        end else begin
            pc_o <= pc_d;
        end
    end

endmodule

// ==== hdl/hazard_unit.sv ====
// hazard unit for the two decode slots
// finds RAW inside the pair and load-use against execute
// encodes the 2-bit issue word
`timescale 1ns/1ps

module hazard_unit (
    // slot 1 fields
    input  logic [pipe_pkg::REG_ADDR_WIDTH-1:0] rd1_i,
    input  logic [pipe_pkg::REG_ADDR_WIDTH-1:0] rs1a_i,
    input  logic [pipe_pkg::REG_ADDR_WIDTH-1:0] rs1b_i,
    input  logic                                valid1_i,
    // slot 2 fields
    input  logic [pipe_pkg::REG_ADDR_WIDTH-1:0] rs2a_i,
    input  logic [pipe_pkg::REG_ADDR_WIDTH-1:0] rs2b_i,
    input  logic                                valid2_i,
    // load currently in execute
    input  logic [pipe_pkg::REG_ADDR_WIDTH-1:0] ex_load_rd_i,
    input  logic                                ex_load_valid_i,

    output logic [1:0]                          issue_inst_o
);

    logic load_live;
    logic load_use1;
    logic load_use2;
    logic raw_pair;
    logic block1;
    logic block2;

    // x0 never carries a dependency
    assign load_live = ex_load_valid_i && (ex_load_rd_i != '0);

    // load-use per slot, either source matches the load target
    assign load_use1 = load_live &&
                       ((rs1a_i == ex_load_rd_i) || (rs1b_i == ex_load_rd_i));
    assign load_use2 = load_live &&
                       ((rs2a_i == ex_load_rd_i) || (rs2b_i == ex_load_rd_i));

    // slot 2 reading the result of slot 1 in the same pair
    assign raw_pair = valid1_i && (rd1_i != '0) &&
                      ((rs2a_i == rd1_i) || (rs2b_i == rd1_i));

    // an empty slot is never blocked
    assign block1 = valid1_i && load_use1;
    assign block2 = valid2_i && (raw_pair || load_use2);

    always_comb begin
        case ({block2, block1})
            2'b00: begin
                issue_inst_o = pipe_pkg::ISSUE_BOTH;
            end
            2'b10: begin
                // older slot goes alone
                issue_inst_o = pipe_pkg::ISSUE_SLOT1;
            end
            2'b01: begin
                // younger slot may pass only if it is independent of slot 1
                issue_inst_o = raw_pair ? pipe_pkg::ISSUE_NONE : pipe_pkg::ISSUE_SLOT2;
            end
            default: begin
                issue_inst_o = pipe_pkg::ISSUE_NONE;
            end
        endcase
    end

endmodule

// ==== hdl/mtimer.sv ====
// machine timer
// free-running counter, compare register, armed flag
// one-cycle interrupt flush on a match
`timescale 1ns/1ps

module mtimer (
    input  logic                            clk,
    input  logic                            reset_i,
    // write restarts the count and arms
    input  logic                            timer_we_i,
    input  logic [pipe_pkg::TIMER_WIDTH-1:0] timer_cmp_i,
    output logic                            timer_flush_o
);

    logic [pipe_pkg::TIMER_WIDTH-1:0] count_q;
    logic [pipe_pkg::TIMER_WIDTH-1:0] cmp_q;
    logic                             armed_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            count_q <= '0;
            armed_q <= 1'b0;
        end else begin
            if (timer_we_i) begin
                // count restarts at the write edge
                count_q <= '0;
                armed_q <= 1'b1;
            end else begin
                count_q <= count_q + 1'b1;
                // one shot, disarm after the match cycle
                if (timer_flush_o) begin
                    armed_q <= 1'b0;
                end
            end
        end
    end

    // compare value only
    always_ff @(posedge clk) begin
        if (timer_we_i) begin
            cmp_q <= timer_cmp_i;
        end
    end

    // match cycle, N edges after the write edge
    assign timer_flush_o = armed_q && (count_q == cmp_q);

    // pulse never stretches unless a new write rearms it
    property p_flush_pulse;
        @(posedge clk) disable iff (reset_i)
            (timer_flush_o && !timer_we_i) |=> !timer_flush_o;
    endproperty

    a_flush_pulse: assert property (p_flush_pulse)
        else $error("timer flush held two cycles");

endmodule

// ==== hdl/pipe_ctrl.sv ====
// pipeline controller
// decodes the issue word into hold and issued-flush terms
// builds the fetch, decode slot and instruction cache stall/flush buses
`timescale 1ns/1ps

module pipe_ctrl (
    // from execute
    input  logic                                 jump_flag_i,
    input  logic [pipe_pkg::INST_ADDR_WIDTH-1:0] jump_addr_i,
    input  logic                                 stall_flag_ex_i,
    // atomic sequencer busy
    input  logic                                 atom_opt_busy_i,
    // interrupt flush from the timer
    input  logic                                 flush_flag_clint_i,
    // issue word from the hazard unit
    input  logic [1:0]                           issue_inst_hdu_i,
    // address generation stall
    input  logic                                 agu_req_stall_i,

    output logic [pipe_pkg::CU_BUS_WIDTH-1:0]    stall_flag_o,
    output logic [pipe_pkg::CU_BUS_WIDTH-1:0]    stall_flag1_o,
    output logic [pipe_pkg::CU_BUS_WIDTH-1:0]    stall_flag2_o,
    output logic [pipe_pkg::CU_BUS_WIDTH-1:0]    stall_flag_icu_o,

    // redirect to fetch
    output logic                                 jump_flag_o,
    output logic [pipe_pkg::INST_ADDR_WIDTH-1:0] jump_addr_o
);

    logic hold_if;
    logic hold_id1;
    logic hold_id2;
    logic issued_id1;
    logic issued_id2;
    logic redirect_flush;

    // pack one bus from its four terms
    function automatic logic [pipe_pkg::CU_BUS_WIDTH-1:0] make_bus(
        input logic stall,
        input logic flush,
        input logic dispatch,
        input logic agu
    );
        logic [pipe_pkg::CU_BUS_WIDTH-1:0] bus;
        bus                               = '0;
        bus[pipe_pkg::CU_STALL]           = stall;
        bus[pipe_pkg::CU_FLUSH]           = flush;
        bus[pipe_pkg::CU_STALL_DISPATCH]  = dispatch;
        bus[pipe_pkg::CU_STALL_AGU]       = agu;
        return bus;
    endfunction

    // per-stage hold and issued-flush from the issue word
    always_comb begin
        hold_if    = 1'b0;
        hold_id1   = 1'b0;
        hold_id2   = 1'b0;
        issued_id1 = 1'b0;
        issued_id2 = 1'b0;
        case (issue_inst_hdu_i)
            pipe_pkg::ISSUE_NONE: begin
                hold_if  = 1'b1;
                hold_id1 = 1'b1;
                hold_id2 = 1'b1;
            end
            pipe_pkg::ISSUE_SLOT1: begin
                // slot 1 left, its decode register empties
                hold_if    = 1'b1;
                hold_id2   = 1'b1;
                issued_id1 = 1'b1;
            end
            pipe_pkg::ISSUE_SLOT2: begin
                hold_if    = 1'b1;
                hold_id1   = 1'b1;
                issued_id2 = 1'b1;
            end
            default: begin
                // both issued, pipeline flows
            end
        endcase
    end

    // jump waits for execute and for any atomic in flight
    assign jump_flag_o = jump_flag_i & ~stall_flag_ex_i & ~atom_opt_busy_i;
    assign jump_addr_o = jump_addr_i;

    // taken jump or interrupt kills everything younger
    assign redirect_flush = jump_flag_o | flush_flag_clint_i;

    // fetch
    assign stall_flag_o = make_bus(stall_flag_ex_i | (hold_if & ~jump_flag_i),
                                   redirect_flush, stall_flag_ex_i, agu_req_stall_i);
    // decode slot 1
    assign stall_flag1_o = make_bus(stall_flag_ex_i | (hold_id1 & ~jump_flag_i),
                                    redirect_flush | issued_id1,
                                    stall_flag_ex_i, agu_req_stall_i);
    // decode slot 2
    assign stall_flag2_o = make_bus(stall_flag_ex_i | (hold_id2 & ~jump_flag_i),
                                    redirect_flush | issued_id2,
                                    stall_flag_ex_i, agu_req_stall_i);
    // instruction cache only stalls on the AGU
    assign stall_flag_icu_o = make_bus(agu_req_stall_i, redirect_flush,
                                       stall_flag_ex_i, agu_req_stall_i);

endmodule

// ==== hdl/pipe_pkg.sv ====
// shared constants for the dual-issue pipeline control
// bus widths, stall/flush bit positions, issue word codes
// reset and trap addresses, atomic sequencer states, timer width
package pipe_pkg;

    // datapath widths
    localparam int INST_ADDR_WIDTH = 32;
    localparam int REG_ADDR_WIDTH  = 5;
    localparam int CU_BUS_WIDTH    = 4;

    // bit positions inside every stall/flush bus
    localparam int CU_STALL          = 0;
    localparam int CU_FLUSH          = 1;
    localparam int CU_STALL_DISPATCH = 2;
    localparam int CU_STALL_AGU      = 3;

    // issue word from the hazard unit, bit 0 is slot 1
    localparam logic [1:0] ISSUE_NONE  = 2'b00;
    localparam logic [1:0] ISSUE_SLOT1 = 2'b01;
    localparam logic [1:0] ISSUE_SLOT2 = 2'b10;
    localparam logic [1:0] ISSUE_BOTH  = 2'b11;

    // fetch addresses
    localparam logic [INST_ADDR_WIDTH-1:0] RESET_PC   = 32'h0000_0000;
    localparam logic [INST_ADDR_WIDTH-1:0] TRAP_VEC   = 32'h0000_0100;
    // one fetch brings an instruction pair
    localparam logic [INST_ADDR_WIDTH-1:0] FETCH_STEP = 32'd8;

    // atomic read-modify-write sequencer
    localparam int         ATOM_BUSY_CYCLES = 3;
    localparam int         ATOM_STATE_WIDTH = 2;
    localparam logic [1:0] ATOM_IDLE        = 2'd0;
    localparam logic [1:0] ATOM_LOCK        = 2'd1;
    localparam logic [1:0] ATOM_READ        = 2'd2;
    localparam logic [1:0] ATOM_WRITE       = 2'd3;

    // machine timer counter and compare width
    localparam int TIMER_WIDTH = 16;

endpackage

// ==== hdl/pipe_top.sv ====
// pipeline control top level
// hazard unit, controller, atomic sequencer, timer, fetch pc
`timescale 1ns/1ps

module pipe_top (
    input  logic                                 clk,
    input  logic                                 reset_i,
    // decode slot 1
    input  logic [pipe_pkg::REG_ADDR_WIDTH-1:0]  rd1_i,
    input  logic [pipe_pkg::REG_ADDR_WIDTH-1:0]  rs1a_i,
    input  logic [pipe_pkg::REG_ADDR_WIDTH-1:0]  rs1b_i,
    input  logic                                 valid1_i,
    // decode slot 2
    input  logic [pipe_pkg::REG_ADDR_WIDTH-1:0]  rs2a_i,
    input  logic [pipe_pkg::REG_ADDR_WIDTH-1:0]  rs2b_i,
    input  logic                                 valid2_i,
    // load in execute
    input  logic [pipe_pkg::REG_ADDR_WIDTH-1:0]  ex_load_rd_i,
    input  logic                                 ex_load_valid_i,
    // execute and agu requests
    input  logic                                 jump_flag_i,
    input  logic [pipe_pkg::INST_ADDR_WIDTH-1:0] jump_addr_i,
    input  logic                                 stall_flag_ex_i,
    input  logic                                 agu_req_stall_i,
    // atomic start and timer programming
    input  logic                                 atom_start_i,
    input  logic                                 timer_we_i,
    input  logic [pipe_pkg::TIMER_WIDTH-1:0]     timer_cmp_i,

    output logic [pipe_pkg::CU_BUS_WIDTH-1:0]    stall_flag_o,
    output logic [pipe_pkg::CU_BUS_WIDTH-1:0]    stall_flag1_o,
    output logic [pipe_pkg::CU_BUS_WIDTH-1:0]    stall_flag2_o,
    output logic [pipe_pkg::CU_BUS_WIDTH-1:0]    stall_flag_icu_o,
    output logic                                 jump_flag_o,
    output logic [pipe_pkg::INST_ADDR_WIDTH-1:0] jump_addr_o,
    output logic [pipe_pkg::INST_ADDR_WIDTH-1:0] pc_o
);

    logic [1:0] issue_inst;
    logic       atom_busy;
    logic       timer_flush;

    hazard_unit i_hazard_unit (
        .rd1_i           (rd1_i),
        .rs1a_i          (rs1a_i),
        .rs1b_i          (rs1b_i),
        .valid1_i        (valid1_i),
        .rs2a_i          (rs2a_i),
        .rs2b_i          (rs2b_i),
        .valid2_i        (valid2_i),
        .ex_load_rd_i    (ex_load_rd_i),
        .ex_load_valid_i (ex_load_valid_i),
        .issue_inst_o    (issue_inst)
    );

    pipe_ctrl i_pipe_ctrl (
        .jump_flag_i        (jump_flag_i),
        .jump_addr_i        (jump_addr_i),
        .stall_flag_ex_i    (stall_flag_ex_i),
        .atom_opt_busy_i    (atom_busy),
        .flush_flag_clint_i (timer_flush),
        .issue_inst_hdu_i   (issue_inst),
        .agu_req_stall_i    (agu_req_stall_i),
        .stall_flag_o       (stall_flag_o),
        .stall_flag1_o      (stall_flag1_o),
        .stall_flag2_o      (stall_flag2_o),
        .stall_flag_icu_o   (stall_flag_icu_o),
        .jump_flag_o        (jump_flag_o),
        .jump_addr_o        (jump_addr_o)
    );

    atom_fsm i_atom_fsm (
        .clk          (clk),
        .reset_i      (reset_i),
        .atom_start_i (atom_start_i),
        .atom_busy_o  (atom_busy)
    );

    mtimer i_mtimer (
        .clk           (clk),
        .reset_i       (reset_i),
        .timer_we_i    (timer_we_i),
        .timer_cmp_i   (timer_cmp_i),
        .timer_flush_o (timer_flush)
    );

    // fetch follows the fetch bus and the granted jump
    fetch_pc i_fetch_pc (
        .clk         (clk),
        .reset_i     (reset_i),
        .fetch_bus_i (stall_flag_o),
        .jump_flag_i (jump_flag_o),
        .jump_addr_i (jump_addr_o),
        .trap_i      (timer_flush),
        .pc_o        (pc_o)
    );

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the pipeline control testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_pipe_top -f files.f \
    --Mdir obj_dir -o sim_pipe > build.log 2>&1 \
    && ./obj_dir/sim_pipe > sim.log 2>&1 \
    || { echo "build or simulation failed, see build.log and sim.log"; exit 1; }

cat sim.log
grep -q "ALL TESTS PASSED" sim.log && exit 0 || exit 1

// ==== tests/tb_pipe_top.sv ====
// testbench for the pipeline control top level
// table of issue, jump and stall cases, then atomic and timer sequences
// register numbers for hazard-free rows come from a Galois LFSR
`timescale 1ns/1ps

module tb_pipe_top;

    // register patterns that select the hazard case
    localparam logic [1:0] PAT_FREE = 2'd0;
    localparam logic [1:0] PAT_RAW  = 2'd1;
    localparam logic [1:0] PAT_LU1  = 2'd2;
    localparam logic [1:0] PAT_LU2  = 2'd3;
    localparam int NUM_ROWS   = 12;
    localparam int WAIT_LIMIT = 20;

    // one stimulus row with its expected responses
    typedef struct packed {
        logic [1:0] pattern;
        logic       valid1;
        logic       valid2;
        logic       jump;
        logic       stall_ex;
        logic       agu;
        logic [3:0] exp_fetch;
        logic [3:0] exp_id1;
        logic [3:0] exp_id2;
        logic [3:0] exp_icu;
        logic       exp_jump;
        logic       exp_pc_jump;
        logic [7:0] exp_pc_step;
    } row_t;

    logic        clk;
    logic        reset_i;
    logic [4:0]  rd1_i, rs1a_i, rs1b_i, rs2a_i, rs2b_i, ex_load_rd_i;
    logic        valid1_i, valid2_i, ex_load_valid_i;
    logic        jump_flag_i;
    logic [31:0] jump_addr_i;
    logic        stall_flag_ex_i, agu_req_stall_i, atom_start_i, timer_we_i;
    logic [15:0] timer_cmp_i;
    logic [3:0]  stall_flag_o, stall_flag1_o, stall_flag2_o, stall_flag_icu_o;
    logic        jump_flag_o;
    logic [31:0] jump_addr_o, pc_o;

    row_t        table_q [NUM_ROWS];
    logic [31:0] lfsr_state;
    int          error_count;
    int          tests_passed;
    int          tests_failed;

    pipe_top i_pipe_top (
        .clk (clk), .reset_i (reset_i),
        .rd1_i (rd1_i), .rs1a_i (rs1a_i), .rs1b_i (rs1b_i), .valid1_i (valid1_i),
        .rs2a_i (rs2a_i), .rs2b_i (rs2b_i), .valid2_i (valid2_i),
        .ex_load_rd_i (ex_load_rd_i), .ex_load_valid_i (ex_load_valid_i),
        .jump_flag_i (jump_flag_i), .jump_addr_i (jump_addr_i),
        .stall_flag_ex_i (stall_flag_ex_i), .agu_req_stall_i (agu_req_stall_i),
        .atom_start_i (atom_start_i), .timer_we_i (timer_we_i), .timer_cmp_i (timer_cmp_i),
        .stall_flag_o (stall_flag_o), .stall_flag1_o (stall_flag1_o),
        .stall_flag2_o (stall_flag2_o), .stall_flag_icu_o (stall_flag_icu_o),
        .jump_flag_o (jump_flag_o), .jump_addr_o (jump_addr_o), .pc_o (pc_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end else begin
            return s >> 1;
        end
    endfunction

    // one step per bit taken
    task automatic draw_reg(output logic [4:0] val);
        for (int i = 0; i < 5; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            val[i] = lfsr_state[0];
        end
    endtask

    task automatic compare_word(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0d ns: %s is %h, expected %h", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        if (error_count == errs_before) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, error_count - errs_before);
        end
    endtask

    // register numbers for one hazard case
    task automatic drive_regs(input logic [1:0] pattern);
        logic [4:0] rd, a, b, c, d, l;
        case (pattern)
            PAT_FREE: begin
                draw_reg(rd);
                draw_reg(a);
                draw_reg(b);
                draw_reg(c);
                draw_reg(d);
                draw_reg(l);
                // slot 2 must not read rd1
                if (c == rd) c = rd ^ 5'd1;
                if (d == rd) d = rd ^ 5'd1;
                ex_load_valid_i <= 1'b0;
            end
            PAT_RAW: begin
                rd = 5'd5;
                a = 5'd1;
                b = 5'd2;
                c = 5'd5;
                d = 5'd3;
                l = 5'd9;
                ex_load_valid_i <= 1'b0;
            end
            PAT_LU1: begin
                // load hits slot 1 only, slot 2 independent
                rd = 5'd6;
                a = 5'd7;
                b = 5'd2;
                c = 5'd3;
                d = 5'd4;
                l = 5'd7;
                ex_load_valid_i <= 1'b1;
            end
            default: begin
                rd = 5'd6;
                a = 5'd7;
                b = 5'd2;
                c = 5'd3;
                d = 5'd7;
                l = 5'd7;
                ex_load_valid_i <= 1'b1;
            end
        endcase
        rd1_i <= rd;
        rs1a_i <= a;
        rs1b_i <= b;
        rs2a_i <= c;
        rs2b_i <= d;
        ex_load_rd_i <= l;
    endtask

    task automatic set_idle();
        valid1_i <= 1'b0;
        valid2_i <= 1'b0;
        ex_load_valid_i <= 1'b0;
        jump_flag_i <= 1'b0;
        stall_flag_ex_i <= 1'b0;
        agu_req_stall_i <= 1'b0;
        atom_start_i <= 1'b0;
        timer_we_i <= 1'b0;
    endtask

    // bus bits are agu, dispatch, flush, stall from msb down
    task automatic fill_table();
        // issue cases
        table_q[0]  = '{PAT_FREE, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0,
                        4'b0000, 4'b0000, 4'b0000, 4'b0000, 1'b0, 1'b0, 8'd8};
        table_q[1]  = '{PAT_RAW, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0,
                        4'b0001, 4'b0010, 4'b0001, 4'b0000, 1'b0, 1'b0, 8'd0};
        table_q[2]  = '{PAT_LU1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0,
                        4'b0001, 4'b0001, 4'b0010, 4'b0000, 1'b0, 1'b0, 8'd0};
        table_q[3]  = '{PAT_LU2, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0,
                        4'b0001, 4'b0001, 4'b0001, 4'b0000, 1'b0, 1'b0, 8'd0};
        // empty slots always issue
        table_q[4]  = '{PAT_LU2, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0,
                        4'b0000, 4'b0000, 4'b0000, 4'b0000, 1'b0, 1'b0, 8'd8};
        // jumps, granted then suppressed by execute
        table_q[5]  = '{PAT_FREE, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0,
                        4'b0010, 4'b0010, 4'b0010, 4'b0010, 1'b1, 1'b1, 8'd0};
        table_q[6]  = '{PAT_LU2, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0,
                        4'b0010, 4'b0010, 4'b0010, 4'b0010, 1'b1, 1'b1, 8'd0};
        table_q[7]  = '{PAT_FREE, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0,
                        4'b0101, 4'b0101, 4'b0101, 4'b0100, 1'b0, 1'b0, 8'd0};
        // agu and execute stalls
        table_q[8]  = '{PAT_FREE, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1,
                        4'b1000, 4'b1000, 4'b1000, 4'b1001, 1'b0, 1'b0, 8'd8};
        table_q[9]  = '{PAT_FREE, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0,
                        4'b0101, 4'b0101, 4'b0101, 4'b0100, 1'b0, 1'b0, 8'd0};
        table_q[10] = '{PAT_FREE, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1,
                        4'b1101, 4'b1101, 4'b1101, 4'b1101, 1'b0, 1'b0, 8'd0};
        table_q[11] = '{PAT_RAW, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1,
                        4'b1001, 4'b1010, 4'b1001, 4'b1001, 1'b0, 1'b0, 8'd0};
    endtask

    task automatic apply_row(input int idx);
        row_t        r;
        logic [31:0] target;
        logic [31:0] pc_start;
        logic [31:0] pc_exp;
        int          errs_before;
        r = table_q[idx];
        target = 32'h0000_0400 + 32'(idx) * 32'h40;
        errs_before = error_count;
        @(posedge clk);
        drive_regs(r.pattern);
        valid1_i <= r.valid1;
        valid2_i <= r.valid2;
        jump_flag_i <= r.jump;
        jump_addr_i <= target;
        stall_flag_ex_i <= r.stall_ex;
        agu_req_stall_i <= r.agu;
        // combinational outputs settle before the falling edge
        @(negedge clk);
        pc_start = pc_o;
        compare_word("fetch bus", 32'(stall_flag_o), 32'(r.exp_fetch));
        compare_word("slot 1 bus", 32'(stall_flag1_o), 32'(r.exp_id1));
        compare_word("slot 2 bus", 32'(stall_flag2_o), 32'(r.exp_id2));
        compare_word("icu bus", 32'(stall_flag_icu_o), 32'(r.exp_icu));
        compare_word("jump flag", 32'(jump_flag_o), 32'(r.exp_jump));
        compare_word("jump addr", jump_addr_o, target);
        @(posedge clk);
        set_idle();
        @(negedge clk);
        if (r.exp_pc_jump) begin
            pc_exp = target;
        end else begin
            pc_exp = pc_start + 32'(r.exp_pc_step);
        end
        compare_word("pc", pc_o, pc_exp);
        end_test($sformatf("row %0d", idx), errs_before);
    endtask

    // busy seen as a held jump that is not granted
    task automatic run_atomic();
        int          errs_before;
        int          waited;
        int          low_cycles;
        logic [31:0] pc_exp;
        errs_before = error_count;
        waited = 0;
        low_cycles = 0;
        // jump lands once before busy rises, then fetch steps unstalled while held
        pc_exp = 32'h0000_0800 + 32'(pipe_pkg::ATOM_BUSY_CYCLES) * 32'd8;
        @(posedge clk);
        jump_flag_i <= 1'b1;
        jump_addr_i <= 32'h0000_0800;
        atom_start_i <= 1'b1;
        @(negedge clk);
        while (jump_flag_o && waited < WAIT_LIMIT) begin
            @(posedge clk);
            @(negedge clk);
            waited++;
        end
        if (jump_flag_o) begin
            $display("atomic busy never suppressed the jump, wait timed out");
            error_count++;
        end else begin
            // second start cycle lands in LOCK and is ignored
            while (!jump_flag_o && low_cycles < WAIT_LIMIT) begin
                low_cycles++;
                compare_word("fetch flush while busy", 32'(stall_flag_o[1]), 32'd0);
                @(posedge clk);
                atom_start_i <= 1'b0;
                @(negedge clk);
            end
            compare_word("busy cycles", 32'(low_cycles), 32'(pipe_pkg::ATOM_BUSY_CYCLES));
            compare_word("pc after release", pc_o, pc_exp);
        end
        @(posedge clk);
        set_idle();
        end_test("atomic", errs_before);
    endtask

    task automatic run_timer(input logic [15:0] cmp);
        int errs_before;
        int cycles;
        errs_before = error_count;
        cycles = 0;
        @(posedge clk);
        timer_we_i <= 1'b1;
        timer_cmp_i <= cmp;
        // write edge
        @(posedge clk);
        timer_we_i <= 1'b0;
        @(negedge clk);
        while (!stall_flag_icu_o[1] && cycles < 32'(cmp) + WAIT_LIMIT) begin
            @(posedge clk);
            @(negedge clk);
            cycles++;
        end
        if (!stall_flag_icu_o[1]) begin
            $display("timer flush never appeared, wait timed out");
            error_count++;
        end else begin
            compare_word("flush delay", 32'(cycles), 32'(cmp));
            compare_word("fetch flush", 32'(stall_flag_o[1]), 32'd1);
            compare_word("slot 1 flush", 32'(stall_flag1_o[1]), 32'd1);
            compare_word("slot 2 flush", 32'(stall_flag2_o[1]), 32'd1);
            @(posedge clk);
            @(negedge clk);
            compare_word("pc after trap", pc_o, pipe_pkg::TRAP_VEC);
            compare_word("flush after pulse", 32'(stall_flag_icu_o[1]), 32'd0);
        end
        end_test($sformatf("timer %0d", cmp), errs_before);
    endtask

    initial begin
        int errs_before;
        reset_i = 1'b1;
        rd1_i = '0;
        rs1a_i = '0;
        rs1b_i = '0;
        rs2a_i = '0;
        rs2b_i = '0;
        ex_load_rd_i = '0;
        valid1_i = 1'b0;
        valid2_i = 1'b0;
        ex_load_valid_i = 1'b0;
        jump_flag_i = 1'b0;
        jump_addr_i = '0;
        stall_flag_ex_i = 1'b0;
        agu_req_stall_i = 1'b0;
        atom_start_i = 1'b0;
        timer_we_i = 1'b0;
        timer_cmp_i = '0;
        lfsr_state = 32'h1536;
        error_count = 0;
        tests_passed = 0;
        tests_failed = 0;
        fill_table();
        repeat (16) @(posedge clk);
        reset_i <= 1'b0;
        @(negedge clk);
        errs_before = error_count;
        compare_word("reset pc", pc_o, pipe_pkg::RESET_PC);
        compare_word("reset flush", 32'(stall_flag_icu_o[1]), 32'd0);
        compare_word("reset jump", 32'(jump_flag_o), 32'd0);
        end_test("reset", errs_before);
        for (int i = 0; i < NUM_ROWS; i++) begin
            apply_row(i);
        end
        run_atomic();
        run_timer(16'd5);
        run_timer(16'd12);
        $display("tests passed %0d, failed %0d, errors %0d",
                 tests_passed, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
